// File: design/debug_pkg.sv
package debug_pkg;

    typedef logic [31:0] word_t;

    // Instruction word
    //   [31:26] opcode, [25:21] rd, [20:16] rs, [15:0] signed immediate
    // ADD takes its second source register from imm[15:11]
    // Only the low bits that select an existing register are decoded
    typedef enum logic [5:0] {
        OP_ADDI = 6'h01,    // rd = rs + imm
        OP_ADD  = 6'h02,    // rd = rs + rt
        OP_LW   = 6'h03,    // rd = mem[rs + imm]
        OP_SW   = 6'h04,    // mem[rs + imm] = rd
        OP_BEQZ = 6'h05,    // If rd is zero, pc = pc + 1 + imm
        OP_HALT = 6'h3f     // All ones, same as the load terminator
    } opcode_e;

    // Host command bytes
    localparam logic [7:0] CMD_LOAD = 8'h6c;   // 'l'
    localparam logic [7:0] CMD_RUN  = 8'h72;   // 'r'
    localparam logic [7:0] CMD_STEP = 8'h73;   // 's'
    localparam logic [7:0] CMD_NEXT = 8'h6e;   // 'n'

    localparam word_t HALT_WORD = 32'hffff_ffff;

endpackage

// File: design/mem_bus_if.sv
`timescale 1ns/1ns

interface mem_bus_if #(
    parameter int ADDR_W = 6
);
    logic                req;      // Held with we/addr/wdata until gnt
    logic                we;
    logic [ADDR_W-1:0]   addr;
    debug_pkg::word_t    wdata;
    logic                gnt;      // Same cycle as req
    debug_pkg::word_t    rdata;    // Cycle after the grant

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata
    );

endinterface

// File: design/core_dbg_if.sv
`timescale 1ns/1ns

interface core_dbg_if #(
    parameter int REG_W = 3
);
    logic                core_reset;
    logic                run_en;
    logic                step;         // One-cycle pulse, one instruction
    logic [REG_W-1:0]    reg_sel;
    logic                halted;       // Level until core_reset
    logic                retired;      // One-cycle pulse per instruction
    debug_pkg::word_t    pc;
    debug_pkg::word_t    cycle_count;
    debug_pkg::word_t    reg_data;     // Combinational from reg_sel

    modport debug (
        output core_reset, run_en, step, reg_sel,
        input  halted, retired, pc, cycle_count, reg_data
    );

    modport core (
        input  core_reset, run_en, step, reg_sel,
        output halted, retired, pc, cycle_count, reg_data
    );

endinterface

// File: design/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter #(
    parameter int MEM_WORDS = 64
) (
    input  logic                          clk,
    input  logic                          reset,
    mem_bus_if.arbiter                    core_bus,
    mem_bus_if.arbiter                    dbg_bus,
    output logic                          o_mem_we,
    output logic [$clog2(MEM_WORDS)-1:0]  o_mem_addr,
    output debug_pkg::word_t              o_mem_wdata,
    input  debug_pkg::word_t              i_mem_rdata
);
    logic core_owned;   // Core held the port on the last grant

    // Core always wins
    assign core_bus.gnt = core_bus.req;
    assign dbg_bus.gnt  = dbg_bus.req && !core_bus.req;

    always_comb begin
        if (core_bus.req) begin
            o_mem_we    = core_bus.we;
            o_mem_addr  = core_bus.addr;
            o_mem_wdata = core_bus.wdata;
        end else begin
            o_mem_we    = dbg_bus.req && dbg_bus.we;
            o_mem_addr  = dbg_bus.addr;
            o_mem_wdata = dbg_bus.wdata;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            core_owned <= 1'b0;
        end else if (core_bus.gnt || dbg_bus.gnt) begin
            core_owned <= core_bus.gnt;
        end
    end

    // Read data goes back only to the bus that was granted
    assign core_bus.rdata = core_owned ? i_mem_rdata : '0;
    assign dbg_bus.rdata  = core_owned ? '0 : i_mem_rdata;

    // A waiting debug request must stay put until it is granted
    a_dbg_held: assert property (@(posedge clk) disable iff (reset)
        (dbg_bus.req && !dbg_bus.gnt) |=>
            (dbg_bus.req && $stable(dbg_bus.we) && $stable(dbg_bus.addr)
             && $stable(dbg_bus.wdata)));

endmodule

// File: design/unified_mem.sv
`timescale 1ns/1ns

module unified_mem #(
    parameter int MEM_WORDS = 64
) (
    input  logic                          clk,
    input  logic                          i_we,
    input  logic [$clog2(MEM_WORDS)-1:0]  i_addr,
    input  debug_pkg::word_t              i_wdata,
    output debug_pkg::word_t              o_rdata
);
    debug_pkg::word_t mem [MEM_WORDS];   // Program and data share it

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
        o_rdata <= mem[i_addr];
    end

endmodule

// File: design/mini_core.sv
`timescale 1ns/1ns

module mini_core #(
    parameter int REG_COUNT = 8,
    parameter int MEM_WORDS = 64
) (
    input  logic           clk,
    input  logic           reset,
    mem_bus_if.requester   mem,
    core_dbg_if.core       dbg
);
    localparam int RW = $clog2(REG_COUNT);
    localparam int AW = $clog2(MEM_WORDS);

    typedef enum logic [2:0] {S_FETCH, S_EXEC, S_MEM, S_LOAD, S_HALT} core_state_e;

    core_state_e         state;
    debug_pkg::word_t    pc;
    debug_pkg::word_t    cycle_count;
    debug_pkg::word_t    regs [REG_COUNT];
    debug_pkg::word_t    ir;
    debug_pkg::word_t    instr;
    debug_pkg::word_t    imm;
    debug_pkg::word_t    rs_val;
    debug_pkg::word_t    rt_val;
    debug_pkg::word_t    rd_val;
    debug_pkg::opcode_e  op;
    logic [RW-1:0]       rd;
    logic [RW-1:0]       rs;
    logic [RW-1:0]       rt;
    logic [AW-1:0]       maddr;
    logic                stepping;
    logic                go;

    // Fetched word is live only in EXEC, later states use the copy
    assign instr  = (state == S_EXEC) ? mem.rdata : ir;
    assign op     = debug_pkg::opcode_e'(instr[31:26]);
    assign rd     = instr[21 +: RW];
    assign rs     = instr[16 +: RW];
    assign rt     = instr[11 +: RW];
    assign imm    = {{16{instr[15]}}, instr[15:0]};
    assign rd_val = (rd == '0) ? '0 : regs[rd];
    assign rs_val = (rs == '0) ? '0 : regs[rs];
    assign rt_val = (rt == '0) ? '0 : regs[rt];
    assign maddr  = AW'(rs_val + imm);
    assign go     = (dbg.run_en || stepping) && !dbg.core_reset;

    assign dbg.halted      = (state == S_HALT);
    assign dbg.pc          = pc;
    assign dbg.cycle_count = cycle_count;
    assign dbg.reg_data    = (dbg.reg_sel == '0) ? '0 : regs[dbg.reg_sel];

    always_comb begin
        mem.req   = 1'b0;
        mem.we    = 1'b0;
        mem.addr  = pc[AW-1:0];
        mem.wdata = rd_val;
        if (state == S_FETCH) begin
            mem.req = go;
        end else if (state == S_MEM) begin
            mem.req  = 1'b1;
            mem.we   = (op == debug_pkg::OP_SW);
            mem.addr = maddr;
        end
    end

    always_comb begin
        case (state)
            S_EXEC:  dbg.retired = (op != debug_pkg::OP_LW) && (op != debug_pkg::OP_SW);
            S_MEM:   dbg.retired = mem.gnt && (op == debug_pkg::OP_SW);
            S_LOAD:  dbg.retired = 1'b1;
            default: dbg.retired = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= S_FETCH;
            pc          <= '0;
            cycle_count <= '0;
            stepping    <= 1'b0;
        end else if (dbg.core_reset) begin
            state       <= S_FETCH;
            pc          <= '0;
            cycle_count <= '0;
            stepping    <= 1'b0;
        end else begin
            if (dbg.step) begin
                stepping <= 1'b1;
            end else if (dbg.retired) begin
                stepping <= 1'b0;
            end
            if ((dbg.run_en || stepping) && state != S_HALT) begin
                cycle_count <= cycle_count + 1;
            end
            case (state)
                S_FETCH: if (mem.gnt) state <= S_EXEC;
                S_EXEC: begin
                    pc    <= pc + 1;
                    state <= S_FETCH;
                    case (op)
                        debug_pkg::OP_LW,
                        debug_pkg::OP_SW:   state <= S_MEM;
                        debug_pkg::OP_BEQZ: if (rd_val == '0) pc <= pc + 1 + imm;
                        debug_pkg::OP_HALT: begin
                            pc    <= pc;    // PC stays on the HALT
                            state <= S_HALT;
                        end
                        default: ;
                    endcase
                end
                S_MEM:   if (mem.gnt) state <= (op == debug_pkg::OP_LW) ? S_LOAD : S_FETCH;
                S_LOAD:  state <= S_FETCH;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_EXEC) begin
            ir <= instr;
        end
        if (dbg.core_reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (state == S_EXEC && op == debug_pkg::OP_ADDI) begin
            regs[rd] <= rs_val + imm;
        end else if (state == S_EXEC && op == debug_pkg::OP_ADD) begin
            regs[rd] <= rs_val + rt_val;
        end else if (state == S_LOAD) begin
            regs[rd] <= mem.rdata;
        end
    end

    a_quiet_when_stopped: assert property (@(posedge clk) disable iff (reset)
        (dbg.halted || dbg.core_reset) |-> !mem.req);

endmodule

// File: design/debug_unit.sv
`timescale 1ns/1ns

module debug_unit #(
    parameter int REG_COUNT  = 8,
    parameter int MEM_WORDS  = 64,
    parameter int DATA_BASE  = 32,
    parameter int DUMP_WORDS = 4
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           i_rx_valid,
    input  logic [7:0]     i_rx_data,
    input  logic           i_tx_done,
    output logic           o_tx_start,
    output logic [7:0]     o_tx_data,
    mem_bus_if.requester   mem,
    core_dbg_if.debug      core
);
    localparam int RW         = $clog2(REG_COUNT);
    localparam int AW         = $clog2(MEM_WORDS);
    localparam int DUMP_TOTAL = 2 + REG_COUNT + DUMP_WORDS;   // Words per dump
    localparam int DW         = $clog2(DUMP_TOTAL);
    localparam logic [DW-1:0] REG_FIRST = DW'(2);
    localparam logic [DW-1:0] MEM_FIRST = DW'(2 + REG_COUNT);
    localparam logic [DW-1:0] DUMP_LAST = DW'(DUMP_TOTAL - 1);

    typedef enum logic [3:0] {
        IDLE, LOAD_BYTES, LOAD_WRITE, RUN_WAIT, STEP_WAIT, STEP_EXEC,
        DUMP_FETCH, DUMP_SEND, DUMP_WAIT
    } dbg_state_e;

    dbg_state_e          state;
    debug_pkg::word_t    load_word;
    debug_pkg::word_t    tx_word;
    logic [1:0]          rx_cnt;
    logic [1:0]          tx_cnt;
    logic [AW-1:0]       load_addr;
    logic [AW-1:0]       dump_addr;
    logic [DW-1:0]       dump_idx;
    logic                step_mode;
    logic                mem_slot;
    logic                rd_pend;      // Dump read granted, data next cycle
    logic                tx_pending;

    assign mem_slot      = (dump_idx >= MEM_FIRST);
    assign dump_addr     = AW'(DATA_BASE) + AW'(dump_idx - MEM_FIRST);
    assign core.reg_sel  = RW'(dump_idx - REG_FIRST);

    assign mem.req   = (state == LOAD_WRITE) || (state == DUMP_FETCH && mem_slot && !rd_pend);
    assign mem.we    = (state == LOAD_WRITE);
    assign mem.addr  = (state == LOAD_WRITE) ? load_addr : dump_addr;
    assign mem.wdata = load_word;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state           <= IDLE;
            rx_cnt          <= '0;
            tx_cnt          <= '0;
            load_addr       <= '0;
            dump_idx        <= '0;
            step_mode       <= 1'b0;
            rd_pend         <= 1'b0;
            o_tx_start      <= 1'b0;
            core.core_reset <= 1'b1;   // Core waits in reset until r or s
            core.run_en     <= 1'b0;
            core.step       <= 1'b0;
        end else begin
            o_tx_start <= 1'b0;
            core.step  <= 1'b0;
            case (state)
                IDLE: if (i_rx_valid) begin
                    case (i_rx_data)
                        debug_pkg::CMD_LOAD: begin
                            load_addr <= '0;
                            rx_cnt    <= '0;
                            state     <= LOAD_BYTES;
                        end
                        debug_pkg::CMD_RUN: begin
                            core.core_reset <= 1'b0;
                            core.run_en     <= 1'b1;
                            step_mode       <= 1'b0;
                            state           <= RUN_WAIT;
                        end
                        debug_pkg::CMD_STEP: begin
                            core.core_reset <= 1'b0;
                            step_mode       <= 1'b1;
                            state           <= STEP_WAIT;
                        end
                        default: ;   // Unknown byte, ignored
                    endcase
                end
                LOAD_BYTES: if (i_rx_valid) begin
                    rx_cnt <= rx_cnt + 2'd1;
                    if (rx_cnt == 2'd3) state <= LOAD_WRITE;
                end
                LOAD_WRITE: if (mem.gnt) begin
                    load_addr <= load_addr + 1'b1;
                    state     <= (load_word == debug_pkg::HALT_WORD) ? IDLE : LOAD_BYTES;
                end
                RUN_WAIT: if (core.halted) begin
                    core.run_en <= 1'b0;
                    dump_idx    <= '0;
                    state       <= DUMP_FETCH;
                end
                STEP_WAIT: if (i_rx_valid && i_rx_data == debug_pkg::CMD_NEXT) begin
                    core.step <= 1'b1;
                    state     <= STEP_EXEC;
                end
                STEP_EXEC: if (core.retired) begin
                    dump_idx <= '0;
                    state    <= DUMP_FETCH;
                end
                DUMP_FETCH: begin
                    if (!mem_slot || rd_pend) begin
                        rd_pend <= 1'b0;
                        state   <= DUMP_SEND;
                    end else if (mem.gnt) begin
                        rd_pend <= 1'b1;
                    end
                end
                DUMP_SEND: begin
                    o_tx_start <= 1'b1;
                    state      <= DUMP_WAIT;
                end
                DUMP_WAIT: if (i_tx_done) begin
                    tx_cnt <= tx_cnt + 2'd1;
                    if (tx_cnt != 2'd3) begin
                        state <= DUMP_SEND;
                    end else if (dump_idx != DUMP_LAST) begin
                        dump_idx <= dump_idx + 1'b1;
                        state    <= DUMP_FETCH;
                    end else if (step_mode && !core.halted) begin
                        state <= STEP_WAIT;
                    end else begin
                        core.core_reset <= 1'b1;
                        step_mode       <= 1'b0;
                        state           <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == LOAD_BYTES && i_rx_valid) begin
            load_word <= {load_word[23:0], i_rx_data};   // MSB first
        end
        if (state == DUMP_FETCH) begin
            if (dump_idx == '0) begin
                tx_word <= core.pc;
            end else if (dump_idx == DW'(1)) begin
                tx_word <= core.cycle_count;
            end else if (!mem_slot) begin
                tx_word <= core.reg_data;
            end else if (rd_pend) begin
                tx_word <= mem.rdata;
            end
        end
        if (state == DUMP_SEND) begin
            o_tx_data <= tx_word[31:24];
            tx_word   <= {tx_word[23:0], 8'h00};
        end
    end

    // Set by a start, cleared by the transmitter's done
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tx_pending <= 1'b0;
        end else if (o_tx_start) begin
            tx_pending <= 1'b1;
        end else if (i_tx_done) begin
            tx_pending <= 1'b0;
        end
    end

    a_tx_paced: assert property (@(posedge clk) disable iff (reset)
        o_tx_start |-> !tx_pending);

endmodule

// File: design/debug_soc.sv
`timescale 1ns/1ns

module debug_soc #(
    parameter int REG_COUNT  = 8,
    parameter int MEM_WORDS  = 64,
    parameter int DATA_BASE  = 32,
    parameter int DUMP_WORDS = 4
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        i_rx_valid,
    input  logic [7:0]  i_rx_data,
    input  logic        i_tx_done,
    output logic        o_tx_start,
    output logic [7:0]  o_tx_data
);
    localparam int AW = $clog2(MEM_WORDS);
    localparam int RW = $clog2(REG_COUNT);

    logic                mem_we;
    logic [AW-1:0]       mem_addr;
    debug_pkg::word_t    mem_wdata;
    debug_pkg::word_t    mem_rdata;

    mem_bus_if  #(.ADDR_W(AW)) dbg_bus ();
    mem_bus_if  #(.ADDR_W(AW)) core_bus ();
    core_dbg_if #(.REG_W(RW))  dbg_link ();

    debug_unit #(
        .REG_COUNT  (REG_COUNT),
        .MEM_WORDS  (MEM_WORDS),
        .DATA_BASE  (DATA_BASE),
        .DUMP_WORDS (DUMP_WORDS)
    ) u_debug_unit (
        .clk        (clk),
        .reset      (reset),
        .i_rx_valid (i_rx_valid),
        .i_rx_data  (i_rx_data),
        .i_tx_done  (i_tx_done),
        .o_tx_start (o_tx_start),
        .o_tx_data  (o_tx_data),
        .mem        (dbg_bus),
        .core       (dbg_link)
    );

    mini_core #(
        .REG_COUNT (REG_COUNT),
        .MEM_WORDS (MEM_WORDS)
    ) u_mini_core (
        .clk   (clk),
        .reset (reset),
        .mem   (core_bus),
        .dbg   (dbg_link)
    );

    mem_arbiter #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem_arbiter (
        .clk         (clk),
        .reset       (reset),
        .core_bus    (core_bus),
        .dbg_bus     (dbg_bus),
        .o_mem_we    (mem_we),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata),
        .i_mem_rdata (mem_rdata)
    );

    unified_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_unified_mem (
        .clk     (clk),
        .i_we    (mem_we),
        .i_addr  (mem_addr),
        .i_wdata (mem_wdata),
        .o_rdata (mem_rdata)
    );

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 3
) (
    output logic o_clk,
    output logic o_reset
);
    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge o_clk);   // Released on a falling edge
        o_reset = 1'b0;
    end

endmodule

// File: test/tb_debug_soc.sv
`timescale 1ns/1ns

module tb_debug_soc;
    localparam int REG_COUNT  = 8;
    localparam int MEM_WORDS  = 64;
    localparam int DATA_BASE  = 32;
    localparam int DUMP_WORDS = 4;
    localparam int AW         = $clog2(MEM_WORDS);
    localparam int DUMP_LEN   = 2 + REG_COUNT + DUMP_WORDS;
    localparam int DUMP_BYTES = DUMP_LEN * 4;
    localparam int MAX_DELAY  = 8;
    localparam int MAX_STEPS  = 64;
    localparam int MAX_INSTR  = 1000;
    localparam int DUMP_LIMIT = DUMP_BYTES * (MAX_DELAY + 20) + 1000;
    // Four run dumps plus the step dumps, each at worst-case pacing
    localparam int WATCH_CYCLES = (4 + MAX_STEPS) * DUMP_BYTES * (MAX_DELAY + 20) + 20000;

    logic clk, reset, rx_valid, tx_done, tx_start, tx_busy, random_delay, exp_halted;
    logic [7:0] rx_data, tx_data;
    logic [7:0] rx_q [$];          // Every byte the transmitter model accepted
    integer seed;
    int rx_base, test_errors, errors, tests_run, tests_failed;
    debug_pkg::word_t ref_mem [MEM_WORDS];
    debug_pkg::word_t exp_mem [MEM_WORDS];
    debug_pkg::word_t exp_regs [REG_COUNT];
    debug_pkg::word_t exp_pc;
    debug_pkg::word_t dump [DUMP_LEN];
    debug_pkg::word_t first_dump [DUMP_LEN];
    debug_pkg::word_t prog_a [$];
    debug_pkg::word_t prog_b [$];

    tb_clock u_tb_clock (.o_clk(clk), .o_reset(reset));

    debug_soc #(
        .REG_COUNT(REG_COUNT), .MEM_WORDS(MEM_WORDS),
        .DATA_BASE(DATA_BASE), .DUMP_WORDS(DUMP_WORDS)
    ) u_debug_soc (
        .clk(clk), .reset(reset), .i_rx_valid(rx_valid), .i_rx_data(rx_data),
        .i_tx_done(tx_done), .o_tx_start(tx_start), .o_tx_data(tx_data)
    );

    function automatic debug_pkg::word_t encode(debug_pkg::opcode_e op, int rd, int rs, int imm);
        return {op, 5'(rd), 5'(rs), 16'(imm)};
    endfunction

    // Byte transmitter, answers each start with a done after a delay
    initial begin : tx_model
        int delay;
        tx_done = 1'b0;
        tx_busy = 1'b0;
        forever begin
            @(negedge clk);
            if (tx_start) begin
                rx_q.push_back(tx_data);
                tx_busy = 1'b1;
                delay = random_delay ? 1 + ($random(seed) & (MAX_DELAY - 1)) : 2;
                repeat (delay) @(negedge clk);
                tx_done = 1'b1;
                @(negedge clk);
                tx_done = 1'b0;
                tx_busy = 1'b0;
            end
        end
    end

    task automatic send_byte(input logic [7:0] b);
        @(negedge clk);
        rx_valid = 1'b1;
        rx_data  = b;
        @(negedge clk);
        rx_valid = 1'b0;
    endtask

    task automatic load_program(input debug_pkg::word_t prog [$]);
        send_byte(debug_pkg::CMD_LOAD);
        foreach (prog[i]) begin
            for (int b = 3; b >= 0; b--) begin
                send_byte(prog[i][8*b +: 8]);   // MSB first
            end
            ref_mem[i] = prog[i];
        end
        repeat (4) @(negedge clk);
    endtask

    // ISA model, from PC 0 and zeroed registers over the current memory image
    task automatic predict(input int max_instr);
        debug_pkg::word_t ins, imm, sum;
        int rd, rs, rt, n;
        exp_mem    = ref_mem;
        exp_regs   = '{default: '0};
        exp_pc     = '0;
        exp_halted = 1'b0;
        n = 0;
        while (!exp_halted && n < max_instr) begin
            ins = exp_mem[exp_pc[AW-1:0]];
            rd  = int'(ins[25:21]) % REG_COUNT;
            rs  = int'(ins[20:16]) % REG_COUNT;
            rt  = int'(ins[15:11]) % REG_COUNT;
            imm = {{16{ins[15]}}, ins[15:0]};
            sum = exp_regs[rs] + imm;
            exp_pc = exp_pc + 1;
            case (ins[31:26])
                debug_pkg::OP_ADDI: exp_regs[rd] = sum;
                debug_pkg::OP_ADD:  exp_regs[rd] = exp_regs[rs] + exp_regs[rt];
                debug_pkg::OP_LW:   exp_regs[rd] = exp_mem[sum[AW-1:0]];
                debug_pkg::OP_SW:   exp_mem[sum[AW-1:0]] = exp_regs[rd];
                debug_pkg::OP_BEQZ: if (exp_regs[rd] == '0) exp_pc = exp_pc + imm;
                debug_pkg::OP_HALT: begin
                    exp_pc     = exp_pc - 1;
                    exp_halted = 1'b1;
                end
                default: ;   // No-op
            endcase
            exp_regs[0] = '0;
            n++;
        end
    endtask

    task automatic collect_dump(input string name);
        int waited;
        logic [7:0] b;
        waited = 0;
        while ((rx_q.size() - rx_base < DUMP_BYTES || tx_busy) && waited < DUMP_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        assert (rx_q.size() - rx_base == DUMP_BYTES) else begin
            $display("%s: expected a %0d-byte dump but received %0d bytes",
                     name, DUMP_BYTES, rx_q.size() - rx_base);
            test_errors++;
        end
        for (int i = 0; i < DUMP_BYTES; i++) begin
            b = (rx_base + i < rx_q.size()) ? rx_q[rx_base + i] : 8'h00;
            dump[i / 4] = {dump[i / 4][23:0], b};
        end
        rx_base = rx_q.size();
        repeat (2) @(negedge clk);
    endtask

    task automatic check_word(input string name, input string what,
                              input debug_pkg::word_t exp, input debug_pkg::word_t got);
        assert (got === exp) else begin
            $display("Mismatch %s %s: expected %h, actual %h", name, what, exp, got);
            test_errors++;
        end
    endtask

    task automatic check_dump(input string name);
        check_word(name, "pc", exp_pc, dump[0]);
        for (int r = 0; r < REG_COUNT; r++) begin
            check_word(name, $sformatf("r%0d", r), exp_regs[r], dump[2 + r]);
        end
        for (int m = 0; m < DUMP_WORDS; m++) begin
            check_word(name, $sformatf("mem[%0d]", DATA_BASE + m),
                       exp_mem[DATA_BASE + m], dump[2 + REG_COUNT + m]);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: FAILED with %0d errors", name, test_errors);
            tests_failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    task automatic run_and_check(input string name);
        send_byte(debug_pkg::CMD_RUN);
        collect_dump(name);
        predict(MAX_INSTR);
        check_dump(name);
        ref_mem = exp_mem;
    endtask

    task automatic test_load_run();
        load_program(prog_a);
        run_and_check("load_run");
        check_word("load_run", "halt pc", prog_a.size() - 1, dump[0]);
        assert (dump[1] != '0) else begin
            $display("load_run: cycle count in the dump is zero");
            test_errors++;
        end
        first_dump = dump;
        end_test("load_run");
    endtask

    task automatic test_step();
        int base, k;
        debug_pkg::word_t last_cycles;
        send_byte(debug_pkg::CMD_STEP);
        base = rx_q.size();
        repeat (50) @(negedge clk);
        assert (rx_q.size() == base) else begin
            $display("step: dump bytes were sent before the first n command");
            test_errors++;
        end
        k = 0;
        last_cycles = '0;
        exp_halted = 1'b0;
        while (!exp_halted && k < MAX_STEPS) begin
            k++;
            send_byte(debug_pkg::CMD_NEXT);
            collect_dump("step");
            predict(k);
            check_dump($sformatf("step %0d", k));
            assert (dump[1] > last_cycles) else begin
                $display("step %0d: cycle count %0d did not grow past %0d", k, dump[1], last_cycles);
                test_errors++;
            end
            last_cycles = dump[1];
        end
        assert (exp_halted) else begin
            $display("step: program did not reach HALT within %0d steps", MAX_STEPS);
            test_errors++;
        end
        ref_mem = exp_mem;
        end_test("step");
    endtask

    task automatic test_unknown_cmd();
        int base;
        base = rx_q.size();
        send_byte(8'h78);   // 'x'
        repeat (100) @(negedge clk);
        assert (rx_q.size() == base) else begin
            $display("unknown_cmd: dump bytes were sent after an unknown command");
            test_errors++;
        end
        run_and_check("unknown_cmd");
        end_test("unknown_cmd");
    endtask

    task automatic test_back_pressure();
        int base;
        random_delay = 1'b1;
        run_and_check("back_pressure");
        for (int w = 0; w < DUMP_LEN; w++) begin
            check_word("back_pressure", $sformatf("word %0d", w), first_dump[w], dump[w]);
        end
        base = rx_q.size();
        repeat (200) @(negedge clk);
        assert (rx_q.size() == base) else begin
            $display("back_pressure: extra bytes arrived after the dump");
            test_errors++;
        end
        random_delay = 1'b0;
        end_test("back_pressure");
    endtask

    task automatic test_reload();
        load_program(prog_b);
        run_and_check("reload");
        check_word("reload", "halt pc", prog_b.size() - 1, dump[0]);
        end_test("reload");
    endtask

    initial begin
        seed = 32'hf4a4;
        rx_valid = 1'b0;
        rx_data = 8'h00;
        random_delay = 1'b0;
        rx_base = 0;
        test_errors = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        ref_mem = '{default: '0};
        prog_a = '{
            encode(debug_pkg::OP_ADDI, 1, 0, 3),       // Loop counter
            encode(debug_pkg::OP_ADDI, 7, 0, -2),
            encode(debug_pkg::OP_ADDI, 4, 0, 5),
            encode(debug_pkg::OP_ADD,  2, 2, 4 << 11), // Loop body
            encode(debug_pkg::OP_ADDI, 1, 1, -1),
            encode(debug_pkg::OP_BEQZ, 1, 0, 1),       // Exit to 7
            encode(debug_pkg::OP_BEQZ, 0, 0, -4),      // Back to 3
            encode(debug_pkg::OP_SW,   2, 0, DATA_BASE),
            encode(debug_pkg::OP_SW,   4, 0, DATA_BASE + 1),
            encode(debug_pkg::OP_ADDI, 5, 2, 100),
            encode(debug_pkg::OP_SW,   5, 0, DATA_BASE + 2),
            encode(debug_pkg::OP_SW,   7, 0, DATA_BASE + 3),
            encode(debug_pkg::OP_LW,   6, 0, DATA_BASE + 2),
            encode(debug_pkg::OP_LW,   3, 6, -80),
            debug_pkg::HALT_WORD
        };
        prog_b = '{
            encode(debug_pkg::OP_ADDI, 1, 0, 7),
            encode(debug_pkg::OP_SW,   1, 0, DATA_BASE),
            encode(debug_pkg::OP_ADD,  2, 1, 1 << 11),
            encode(debug_pkg::OP_LW,   3, 0, DATA_BASE + 1),
            debug_pkg::HALT_WORD
        };
        while (reset !== 1'b0) @(negedge clk);
        repeat (2) @(negedge clk);
        test_load_run();
        test_step();
        test_unknown_cmd();
        test_back_pressure();
        test_reload();
        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCH_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCH_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: debug_soc.f
design/debug_pkg.sv
design/mem_bus_if.sv
design/core_dbg_if.sv
design/mem_arbiter.sv
design/unified_mem.sv
design/mini_core.sv
design/debug_unit.sv
design/debug_soc.sv
test/tb_clock.sv
test/tb_debug_soc.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f debug_soc.f \
    --top-module tb_debug_soc -o tb_debug_soc

sim_output=$(./obj_dir/tb_debug_soc)
echo "$sim_output"

if grep -q "Simulation completed successfully" <<< "$sim_output"; then
    exit 0
fi
exit 1
